// File: pipe_ctrl.f
+incdir+verification
src/core_ctrl_pkg.sv
src/stage_if.sv
src/exc_csr_if.sv
src/fwd_hazard_unit.sv
src/redirect_ctrl.sv
src/mach_csr.sv
src/pipe_ctrl.sv
verification/pipe_ctrl_assert.sv
verification/pipe_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the pipe_ctrl testbench with Verilator, run it, grade from the log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pipe_ctrl_tb -f pipe_ctrl.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vpipe_ctrl_tb > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log

grep -q "Test completed successfully" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: verification/pipe_ctrl_model.svh
`ifndef PIPE_CTRL_MODEL_SVH
`define PIPE_CTRL_MODEL_SVH
`default_nettype none

// Operand select, the younger EX result beats MEM
function automatic logic [1:0] fwd_select(
    input logic                                 used,
    input logic [core_ctrl_pkg::REG_ADDR_W-1:0] rs,
    input logic                                 ex_live,   // en and gpr_we
    input logic [core_ctrl_pkg::REG_ADDR_W-1:0] ex_rd,
    input logic                                 mem_live,
    input logic [core_ctrl_pkg::REG_ADDR_W-1:0] mem_rd
);
    if (!used || (rs == '0)) return core_ctrl_pkg::FWD_NONE;   // r0 never forwarded
    if (ex_live && (ex_rd == rs)) return core_ctrl_pkg::FWD_EX;
    if (mem_live && (mem_rd == rs)) return core_ctrl_pkg::FWD_MEM;
    return core_ctrl_pkg::FWD_NONE;
endfunction

// Load in MEM feeding a store in EX
function automatic logic store_data_fwd(
    input logic                                 mem_live,
    input logic [3:0]                           mem_op,
    input logic [3:0]                           ex_op,
    input logic [core_ctrl_pkg::REG_ADDR_W-1:0] rs,
    input logic [core_ctrl_pkg::REG_ADDR_W-1:0] mem_rd
);
    return mem_live && mem_op[3] && (ex_op[3:2] == 2'b01) && (rs != '0) && (rs == mem_rd);
endfunction

// Load in EX whose result a used ID source needs now
function automatic logic load_use_stall(
    input logic                                 ex_live,
    input logic [3:0]                           ex_op,
    input logic [core_ctrl_pkg::REG_ADDR_W-1:0] ex_rd,
    input logic [1:0]                           used,
    input logic [core_ctrl_pkg::REG_ADDR_W-1:0] rs1,
    input logic [core_ctrl_pkg::REG_ADDR_W-1:0] rs2,
    input logic                                 id_store
);
    return ex_live && ex_op[3]
           && ((used[0] && (ex_rd == rs1)) || (used[1] && (ex_rd == rs2) && !id_store));
endfunction

// Packed as {if_stall, if_flush, id_flush, ex_flush, mem_flush}
function automatic logic [4:0] flush_vector(
    input logic trap,
    input logic eret,
    input logic ldh,
    input logic br
);
    return {ldh, trap || eret, trap || ldh || br, trap, trap};
endfunction

// Trap vector first, then the saved return address, else no redirect
function automatic logic [31:0] redirect_target(
    input logic        trap,
    input logic        eret,
    input logic [31:0] vector,
    input logic [31:0] mepc
);
    return trap ? vector : (eret ? mepc : 32'h0);
endfunction

`default_nettype wire
`endif

// File: verification/pipe_ctrl_tb.sv
`timescale 1ns/1ps
`include "pipe_ctrl_model.svh"
`default_nettype none

module pipe_ctrl_tb;
    import core_ctrl_pkg::*;

    localparam logic [WORD_W-1:0] TRAP_VEC = 32'h0000_0200;   // Not the default vector
    localparam int CLK_HALF     = 20;
    localparam int RST_WAIT_MAX = 10;       // Cycles

    logic                  clk, rst;
    logic [1:0]            src_reg_used, rs1_fwd_ctrl, rs2_fwd_ctrl;
    logic [REG_ADDR_W-1:0] id_rs1_addr, id_rs2_addr, ex_rd_addr, mem_rd_addr;
    logic [REG_ADDR_W-1:0] ex_rs1_addr, ex_rs2_addr;
    logic                  id_is_store, ex_en, ex_gpr_we, mem_en, mem_gpr_we;
    logic                  is_eret, br_taken, csr_we, ex_rs1_fwd_en, ex_rs2_fwd_en;
    logic                  if_stall, if_flush, id_flush, ex_flush, mem_flush;
    logic [3:0]            ex_mem_op, mem_mem_op;
    logic [WORD_W-1:0]     mem_pc, csr_wdata, csr_rdata, new_pc;
    logic [EXP_CODE_W-1:0] mem_exp_code;
    logic [CSR_ADDR_W-1:0] csr_waddr, csr_raddr;

    logic [WORD_W-1:0]     m_mepc;          // Model CSR copies
    logic [EXP_CODE_W-1:0] m_mcause;
    logic                  m_trap_act;
    logic                  m_trap, m_eret, m_ex_live, m_mem_live, m_ldh;
    integer                seed;
    logic [31:0]           r;
    int                    err_cnt, test_errs, test_cnt;

    pipe_ctrl #(.TRAP_VECTOR(TRAP_VEC)) u_dut (.*);

    assign m_ex_live  = ex_en && ex_gpr_we;
    assign m_mem_live = mem_en && mem_gpr_we;
    assign m_trap     = mem_en && (mem_exp_code != EXP_NONE);
    assign m_eret     = mem_en && is_eret && !m_trap;      // Trap wins the slot
    assign m_ldh      = load_use_stall(m_ex_live, ex_mem_op, ex_rd_addr, src_reg_used,
                                       id_rs1_addr, id_rs2_addr, id_is_store);

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    function automatic logic [CSR_ADDR_W-1:0] pick_csr(input logic [31:0] v);
        case (v[1:0])
            2'd0:    return CSR_MSTATUS;
            2'd1:    return CSR_MEPC;
            2'd2:    return CSR_MCAUSE;
            default: return v[13:2];        // Mostly unimplemented
        endcase
    endfunction

    function automatic logic [WORD_W-1:0] csr_read(input logic [CSR_ADDR_W-1:0] a);
        case (a)
            CSR_MSTATUS: return {31'b0, m_trap_act};
            CSR_MEPC:    return m_mepc;
            CSR_MCAUSE:  return {28'b0, m_mcause};
            default:     return '0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;                                 // Drive point
    endtask

    // Addresses kept to r0..r3 so stages collide often
    task automatic drive_random(input int mode);
        r = $random(seed);
        src_reg_used = r[1:0];
        id_rs1_addr  = {3'b0, r[3:2]};
        id_rs2_addr  = {3'b0, r[5:4]};
        ex_rd_addr   = {3'b0, r[7:6]};
        mem_rd_addr  = {3'b0, r[9:8]};
        ex_rs1_addr  = {3'b0, r[11:10]};
        ex_rs2_addr  = {3'b0, r[13:12]};
        id_is_store  = r[14];
        ex_en        = r[15] | r[16];       // Live three times in four
        mem_en       = r[17] | r[18];
        ex_gpr_we    = r[19] | r[20];
        mem_gpr_we   = r[21] | r[22];
        ex_mem_op    = r[26:23];
        mem_mem_op   = r[30:27];
        br_taken     = r[31];
        mem_exp_code = EXP_NONE;
        is_eret      = 1'b0;
        csr_we       = 1'b0;
        csr_raddr    = pick_csr($random(seed));
        mem_pc       = $random(seed);
        case (mode)
            1: begin
                ex_en        = 1'b1;
                ex_mem_op[3] = 1'b1;        // Load in EX
            end
            2: begin
                mem_en         = 1'b1;
                mem_mem_op[3]  = 1'b1;      // Load in MEM
                ex_mem_op[3:2] = 2'b01;     // Store in EX
            end
            3: begin
                r = $random(seed);
                csr_we    = r[0] | r[1];
                csr_waddr = pick_csr(r >> 2);
                csr_wdata = $random(seed);
                if (r[6:4] == 3'd0) begin
                    mem_en       = 1'b1;
                    mem_exp_code = r[11:8] | 4'h1;   // Save racing a write
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_outputs();
        logic [4:0] fl;
        fl = flush_vector(m_trap, m_eret, m_ldh, br_taken);
        expect_eq("rs1_fwd_ctrl", 32'(rs1_fwd_ctrl), 32'(fwd_select(src_reg_used[0],
                  id_rs1_addr, m_ex_live, ex_rd_addr, m_mem_live, mem_rd_addr)));
        expect_eq("rs2_fwd_ctrl", 32'(rs2_fwd_ctrl), 32'(fwd_select(src_reg_used[1],
                  id_rs2_addr, m_ex_live, ex_rd_addr, m_mem_live, mem_rd_addr)));
        expect_eq("ex_rs1_fwd_en", 32'(ex_rs1_fwd_en), 32'(store_data_fwd(m_mem_live,
                  mem_mem_op, ex_mem_op, ex_rs1_addr, mem_rd_addr)));
        expect_eq("ex_rs2_fwd_en", 32'(ex_rs2_fwd_en), 32'(store_data_fwd(m_mem_live,
                  mem_mem_op, ex_mem_op, ex_rs2_addr, mem_rd_addr)));
        expect_eq("if_stall", 32'(if_stall), 32'(fl[4]));
        expect_eq("if_flush", 32'(if_flush), 32'(fl[3]));
        expect_eq("id_flush", 32'(id_flush), 32'(fl[2]));
        expect_eq("ex_flush", 32'(ex_flush), 32'(fl[1]));
        expect_eq("mem_flush", 32'(mem_flush), 32'(fl[0]));
        expect_eq("new_pc", new_pc, redirect_target(m_trap, m_eret, TRAP_VEC, m_mepc));
        expect_eq("csr_rdata", csr_rdata, csr_read(csr_raddr));
    endtask

    // Check late in the cycle, then step the model past the coming edge
    task automatic settle_check();
        #30;
        check_outputs();
        if (m_trap) begin
            m_mepc     = mem_pc;
            m_mcause   = mem_exp_code;
            m_trap_act = 1'b1;
        end else begin
            if (csr_we && (csr_waddr == CSR_MEPC)) m_mepc = csr_wdata;
            if (csr_we && (csr_waddr == CSR_MCAUSE)) m_mcause = csr_wdata[3:0];
            if (m_eret) m_trap_act = 1'b0;
        end
    endtask

    task automatic run_random(input int n, input int mode, input string name);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            drive_random(mode);
            settle_check();
        end
        if (name != "") end_test(name);
    endtask

    task automatic end_test(input string name);
        $display("%-22s %s (%0d errors)", name, (test_errs == 0) ? "PASS" : "FAIL", test_errs);
        err_cnt  += test_errs;
        test_errs = 0;
        test_cnt++;
    endtask

    task automatic trap_cycle(input logic with_eret);
        next_cycle();
        drive_random(0);
        r = $random(seed);
        mem_en       = 1'b1;
        mem_exp_code = (r[3:0] == 4'h0) ? 4'hb : r[3:0];   // Any non-zero cause
        is_eret      = with_eret;
        settle_check();
        expect_eq("new_pc", new_pc, TRAP_VEC);
    endtask

    task automatic read_csr_cycle(input logic [CSR_ADDR_W-1:0] addr);
        next_cycle();
        drive_random(0);
        mem_en    = 1'b0;                   // Quiet MEM slot
        csr_raddr = addr;
        settle_check();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_tests();
        for (int i = 0; i < 8; i++) read_csr_cycle(pick_csr($random(seed)));
        end_test("csr reset values");
        run_random(300, 0, "operand forwarding");
        run_random(150, 1, "");
        next_cycle();
        drive_random(1);
        ex_gpr_we    = 1'b1;
        ex_rd_addr   = 5'd2;
        id_rs1_addr  = 5'd3;
        id_rs2_addr  = 5'd2;                // Only the store data matches
        src_reg_used = 2'b11;
        id_is_store  = 1'b1;
        settle_check();
        expect_eq("if_stall", 32'(if_stall), 32'd0);
        end_test("load-use stall");
        run_random(150, 2, "store-data forward");
        for (int i = 0; i < 20; i++) begin
            trap_cycle(1'b0);
            read_csr_cycle(CSR_MEPC);
            read_csr_cycle(CSR_MCAUSE);
            read_csr_cycle(CSR_MSTATUS);
            expect_eq("csr_rdata", csr_rdata, 32'd1);
        end
        end_test("trap entry");
        for (int i = 0; i < 10; i++) begin
            trap_cycle(1'b0);
            next_cycle();
            drive_random(0);
            mem_en  = 1'b1;
            is_eret = 1'b1;
            settle_check();
            expect_eq("new_pc", new_pc, m_mepc);
            expect_eq("ex_flush", 32'(ex_flush), 32'd0);
            read_csr_cycle(CSR_MSTATUS);
            expect_eq("csr_rdata", csr_rdata, 32'd0);
            trap_cycle(1'b1);               // Trap with eret in the same slot
        end
        end_test("return from trap");
        run_random(200, 3, "csr software access");
    endtask

    initial begin
        {src_reg_used, id_rs1_addr, id_rs2_addr, id_is_store} = '0;
        {ex_en, ex_rd_addr, ex_gpr_we, ex_mem_op, ex_rs1_addr, ex_rs2_addr} = '0;
        {mem_en, mem_rd_addr, mem_gpr_we, mem_mem_op, mem_pc, mem_exp_code} = '0;
        {is_eret, br_taken, csr_we, csr_waddr, csr_wdata, csr_raddr} = '0;
        {m_mepc, m_mcause, m_trap_act} = '0;            // Reset state
        seed      = 32'hbfa9;
        err_cnt   = 0;
        test_errs = 0;
        test_cnt  = 0;
        for (int i = 0; (i < RST_WAIT_MAX) && (rst !== 1'b0); i++) @(posedge clk);
        if (rst !== 1'b0) begin
            $display("Timeout waiting for reset release");
            $display("Test failed");
            $finish;
        end else begin
            run_tests();
            $display("%0d tests run, %0d errors", test_cnt, err_cnt);
            if (err_cnt == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/pipe_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_assert (
    input logic clk,
    input logic rst,
    input logic save_exp,                   // Trap strobe to the CSRs
    input logic restore_exp,                // Eret strobe to the CSRs
    input logic if_stall,
    input logic if_flush,
    input logic id_flush,
    input logic ex_flush,
    input logic mem_flush
);

    // A slot either traps or returns, never both
    strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(save_exp && restore_exp))
        else $error("save_exp and restore_exp high in the same cycle");

    stall_bubble: assert property (@(posedge clk) disable iff (rst)
        if_stall |-> id_flush)              // Stalled fetch needs a bubble
        else $error("if_stall without id_flush");

    // Only a trap clears EX, and it clears the whole pipe
    trap_flush: assert property (@(posedge clk) disable iff (rst)
        ex_flush |-> (if_flush && mem_flush))
        else $error("ex_flush without if_flush and mem_flush");

endmodule

bind pipe_ctrl pipe_ctrl_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .save_exp    (exc.save_exp),
    .restore_exp (exc.restore_exp),
    .if_stall    (if_stall),
    .if_flush    (if_flush),
    .id_flush    (id_flush),
    .ex_flush    (ex_flush),
    .mem_flush   (mem_flush)
);

`default_nettype wire

// File: src/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl #(
    parameter logic [core_ctrl_pkg::WORD_W-1:0] TRAP_VECTOR = 32'h0000_0100
) (
    input  logic                                 clk,
    input  logic                                 rst,
    // ID operands
    input  logic [1:0]                           src_reg_used,
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] id_rs1_addr,
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] id_rs2_addr,
    input  logic                                 id_is_store,
    // EX stage
    input  logic                                 ex_en,
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] ex_rd_addr,
    input  logic                                 ex_gpr_we,
    input  logic [3:0]                           ex_mem_op,
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] ex_rs1_addr,
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] ex_rs2_addr,
    // MEM stage
    input  logic                                 mem_en,
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] mem_rd_addr,
    input  logic                                 mem_gpr_we,
    input  logic [3:0]                           mem_mem_op,
    input  logic [core_ctrl_pkg::WORD_W-1:0]     mem_pc,
    input  logic [core_ctrl_pkg::EXP_CODE_W-1:0] mem_exp_code,
    input  logic                                 is_eret,
    input  logic                                 br_taken,
    // CSR software port
    input  logic                                 csr_we,
    input  logic [core_ctrl_pkg::CSR_ADDR_W-1:0] csr_waddr,
    input  logic [core_ctrl_pkg::WORD_W-1:0]     csr_wdata,
    input  logic [core_ctrl_pkg::CSR_ADDR_W-1:0] csr_raddr,
    output logic [core_ctrl_pkg::WORD_W-1:0]     csr_rdata,
    // Forwarding
    output logic [1:0]                           rs1_fwd_ctrl,
    output logic [1:0]                           rs2_fwd_ctrl,
    output logic                                 ex_rs1_fwd_en,
    output logic                                 ex_rs2_fwd_en,
    // Pipeline control
    output logic                                 if_stall,
    output logic                                 if_flush,
    output logic                                 id_flush,
    output logic                                 ex_flush,
    output logic                                 mem_flush,
    output logic [core_ctrl_pkg::WORD_W-1:0]     new_pc
);

    logic ld_hazard;                        // Hazard unit to redirect

    stage_if   ex_stg ();
    stage_if   mem_stg ();
    exc_csr_if exc ();

    // Stage descriptors onto the interfaces
    assign ex_stg.en          = ex_en;
    assign ex_stg.rd_addr     = ex_rd_addr;
    assign ex_stg.gpr_we      = ex_gpr_we;
    assign ex_stg.mem_op.raw  = ex_mem_op;
    assign mem_stg.en         = mem_en;
    assign mem_stg.rd_addr    = mem_rd_addr;
    assign mem_stg.gpr_we     = mem_gpr_we;
    assign mem_stg.mem_op.raw = mem_mem_op;

    fwd_hazard_unit u_fwd (
        .ex_stg        (ex_stg.sink),
        .mem_stg       (mem_stg.sink),
        .src_reg_used  (src_reg_used),
        .id_rs1_addr   (id_rs1_addr),
        .id_rs2_addr   (id_rs2_addr),
        .id_is_store   (id_is_store),
        .ex_rs1_addr   (ex_rs1_addr),
        .ex_rs2_addr   (ex_rs2_addr),
        .rs1_fwd_ctrl  (rs1_fwd_ctrl),
        .rs2_fwd_ctrl  (rs2_fwd_ctrl),
        .ex_rs1_fwd_en (ex_rs1_fwd_en),
        .ex_rs2_fwd_en (ex_rs2_fwd_en),
        .ld_hazard     (ld_hazard)
    );

    redirect_ctrl #(.TRAP_VECTOR(TRAP_VECTOR)) u_redir (
        .mem_en       (mem_en),
        .mem_pc       (mem_pc),
        .mem_exp_code (mem_exp_code),
        .is_eret      (is_eret),
        .br_taken     (br_taken),
        .ld_hazard    (ld_hazard),
        .csr          (exc.ctrl),
        .new_pc       (new_pc),
        .if_stall     (if_stall),
        .if_flush     (if_flush),
        .id_flush     (id_flush),
        .ex_flush     (ex_flush),
        .mem_flush    (mem_flush)
    );

    mach_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .csr       (exc.csr),
        .csr_we    (csr_we),
        .csr_waddr (csr_waddr),
        .csr_wdata (csr_wdata),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata)
    );

endmodule

`default_nettype wire

// File: src/mach_csr.sv
`timescale 1ns/1ps
`default_nettype none

module mach_csr (
    input  logic                                 clk,
    input  logic                                 rst,          // Sync, active high
    exc_csr_if.csr                               csr,
    input  logic                                 csr_we,       // Software write
    input  logic [core_ctrl_pkg::CSR_ADDR_W-1:0] csr_waddr,
    input  logic [core_ctrl_pkg::WORD_W-1:0]     csr_wdata,
    input  logic [core_ctrl_pkg::CSR_ADDR_W-1:0] csr_raddr,
    output logic [core_ctrl_pkg::WORD_W-1:0]     csr_rdata
);
    import core_ctrl_pkg::*;

    logic [WORD_W-1:0]     mepc_q;          // Return address
    logic [EXP_CODE_W-1:0] mcause_q;        // Last trap cause
    logic                  trap_act_q;      // Inside a handler
    logic                  wr_mepc;
    logic                  wr_mcause;

    // Software write decode
    assign wr_mepc   = csr_we && (csr_waddr == CSR_MEPC);
    assign wr_mcause = csr_we && (csr_waddr == CSR_MCAUSE);

    ////////////////////////////////////////////////////////////////////////////
    // Register update
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_q     <= '0;
            mcause_q   <= EXP_NONE;
            trap_act_q <= 1'b0;
        end else begin
            if (csr.save_exp) begin
                mepc_q   <= csr.epc;                    // Hardware beats software
                mcause_q <= csr.exp_code;
            end else begin
                if (wr_mepc) begin
                    mepc_q <= csr_wdata;
                end
                if (wr_mcause) begin
                    mcause_q <= csr_wdata[EXP_CODE_W-1:0]; // Upper bits dropped
                end
            end
            if (csr.save_exp) begin
                trap_act_q <= 1'b1;
            end else if (csr.restore_exp) begin
                trap_act_q <= 1'b0;
            end
        end
    end

    assign csr.mepc = mepc_q;               // Eret target

    ////////////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (csr_raddr)
            CSR_MSTATUS: csr_rdata = {{(WORD_W-1){1'b0}}, trap_act_q};
            CSR_MEPC:    csr_rdata = mepc_q;
            CSR_MCAUSE:  csr_rdata = {{(WORD_W-EXP_CODE_W){1'b0}}, mcause_q};
            default:     csr_rdata = '0;    // Unimplemented reads zero
        endcase
    end

endmodule

`default_nettype wire

// File: src/redirect_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_ctrl #(
    parameter logic [core_ctrl_pkg::WORD_W-1:0] TRAP_VECTOR = 32'h0000_0100
) (
    input  logic                                 mem_en,       // MEM insn live
    input  logic [core_ctrl_pkg::WORD_W-1:0]     mem_pc,
    input  logic [core_ctrl_pkg::EXP_CODE_W-1:0] mem_exp_code,
    input  logic                                 is_eret,      // Return from trap
    input  logic                                 br_taken,
    input  logic                                 ld_hazard,    // From hazard unit
    exc_csr_if.ctrl                              csr,
    output logic [core_ctrl_pkg::WORD_W-1:0]     new_pc,
    output logic                                 if_stall,
    output logic                                 if_flush,
    output logic                                 id_flush,
    output logic                                 ex_flush,
    output logic                                 mem_flush
);
    import core_ctrl_pkg::*;

    logic trap;                             // Precise trap at MEM
    logic eret;                             // Return taken this cycle

    // Trap outranks a return in the same slot
    assign trap = mem_en && (mem_exp_code != EXP_NONE);
    assign eret = mem_en && is_eret && !trap;

    ////////////////////////////////////////////////////////////////////////////
    // Redirect target and CSR strobes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        new_pc          = '0;               // No redirect
        csr.save_exp    = 1'b0;
        csr.restore_exp = 1'b0;
        csr.exp_code    = EXP_NONE;
        csr.epc         = '0;
        if (trap) begin
            new_pc       = TRAP_VECTOR;     // Single entry point
            csr.save_exp = 1'b1;
            csr.exp_code = mem_exp_code;
            csr.epc      = mem_pc;          // Faulting insn restarts
        end else if (eret) begin
            new_pc          = csr.mepc;
            csr.restore_exp = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stall and flush
    ////////////////////////////////////////////////////////////////////////////
    assign if_stall  = ld_hazard;           // Hold fetch on load-use
    assign if_flush  = trap || eret;
    assign id_flush  = trap || ld_hazard || br_taken; // Bubble into EX
    assign ex_flush  = trap;
    assign mem_flush = trap;

endmodule

`default_nettype wire

// File: src/fwd_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_hazard_unit (
    stage_if.sink                           ex_stg,         // Insn now in EX
    stage_if.sink                           mem_stg,        // Insn now in MEM
    input  logic [1:0]                      src_reg_used,   // Bit 0 rs1, bit 1 rs2
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] id_rs1_addr,
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] id_rs2_addr,
    input  logic                            id_is_store,    // ID insn is a store
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] ex_rs1_addr,
    input  logic [core_ctrl_pkg::REG_ADDR_W-1:0] ex_rs2_addr,
    output logic [1:0]                      rs1_fwd_ctrl,
    output logic [1:0]                      rs2_fwd_ctrl,
    output logic                            ex_rs1_fwd_en,  // Late store data from MEM
    output logic                            ex_rs2_fwd_en,
    output logic                            ld_hazard       // Load-use stall request
);
    import core_ctrl_pkg::*;

    logic ex_writes;                        // EX will write a GPR
    logic mem_writes;                       // MEM will write a GPR
    logic ex_is_load;
    logic mem_is_load;
    logic ex_is_store;
    logic rs1_ld_hit;                       // EX load feeds rs1
    logic rs2_ld_hit;                       // EX load feeds rs2

    ////////////////////////////////////////////////////////////////////////////
    // Stage qualification
    ////////////////////////////////////////////////////////////////////////////
    assign ex_writes   = ex_stg.en && ex_stg.gpr_we;
    assign mem_writes  = mem_stg.en && mem_stg.gpr_we;
    assign ex_is_load  = ex_stg.mem_op.fld.is_load;            // 1xxx
    assign mem_is_load = mem_stg.mem_op.fld.is_load;
    // Store bit only counts with the load bit clear
    assign ex_is_store = !ex_stg.mem_op.fld.is_load && ex_stg.mem_op.fld.is_store;

    // Select for one ID operand, EX result is youngest so it wins
    function automatic logic [1:0] fwd_sel(
        input logic                  used,
        input logic [REG_ADDR_W-1:0] rs
    );
        logic [1:0] sel;
        sel = FWD_NONE;
        if (used && (rs != '0)) begin                           // r0 is hardwired
            if (ex_writes && (ex_stg.rd_addr == rs)) begin
                sel = FWD_EX;
            end else if (mem_writes && (mem_stg.rd_addr == rs)) begin
                sel = FWD_MEM;
            end
        end
        return sel;
    endfunction

    // Load in MEM hands its data to a store in EX
    function automatic logic st_data_fwd(
        input logic [REG_ADDR_W-1:0] rs
    );
        logic hit;
        hit = mem_writes && mem_is_load && ex_is_store
              && (rs != '0) && (mem_stg.rd_addr == rs);
        return hit;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding selects
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rs1_fwd_ctrl  = fwd_sel(src_reg_used[0], id_rs1_addr);
        rs2_fwd_ctrl  = fwd_sel(src_reg_used[1], id_rs2_addr);
        ex_rs1_fwd_en = st_data_fwd(ex_rs1_addr);
        ex_rs2_fwd_en = st_data_fwd(ex_rs2_addr);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load-use hazard
    ////////////////////////////////////////////////////////////////////////////
    assign rs1_ld_hit = src_reg_used[0] && (ex_stg.rd_addr == id_rs1_addr);
    assign rs2_ld_hit = src_reg_used[1] && (ex_stg.rd_addr == id_rs2_addr);

    // A store's rs2 is its data, covered later by the MEM to EX path
    // so only its base register must wait for the load
    always_comb begin
        ld_hazard = 1'b0;
        if (ex_writes && ex_is_load) begin
            ld_hazard = rs1_ld_hit || (rs2_ld_hit && !id_is_store);
        end
    end

endmodule

`default_nettype wire

// File: src/exc_csr_if.sv
`timescale 1ns/1ps
`default_nettype none

// Trap save and return path between redirect logic and machine CSRs
interface exc_csr_if;
    import core_ctrl_pkg::*;

    logic                  save_exp;        // One-cycle trap strobe
    logic                  restore_exp;     // One-cycle eret strobe
    logic [EXP_CODE_W-1:0] exp_code;        // Cause to latch on save
    logic [WORD_W-1:0]     epc;             // PC to latch on save
    logic [WORD_W-1:0]     mepc;            // Stored return address

    // Redirect side
    modport ctrl (output save_exp, restore_exp, exp_code, epc,
                  input  mepc);

    // CSR side
    modport csr (input  save_exp, restore_exp, exp_code, epc,
                 output mepc);

endinterface

`default_nettype wire

// File: src/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// Destination side of one pipeline stage
interface stage_if;
    import core_ctrl_pkg::*;

    logic                  en;              // Stage holds a live insn
    logic [REG_ADDR_W-1:0] rd_addr;         // GPR destination
    logic                  gpr_we;          // Writes the GPR file, active high
    mem_op_u               mem_op;          // Load/store class and size

    // Filled from the pipeline registers
    modport src (output en, rd_addr, gpr_we, mem_op);

    // Seen by the hazard logic
    modport sink (input en, rd_addr, gpr_we, mem_op);

endinterface

`default_nettype wire

// File: src/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int WORD_W     = 32;             // Data and address width
    localparam int REG_ADDR_W = 5;              // GPR index width
    localparam int EXP_CODE_W = 4;              // Exception cause width
    localparam int CSR_ADDR_W = 12;             // CSR space width

    ////////////////////////////////////////////////////////////////////////////
    // Operand forwarding selects
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [1:0] FWD_NONE = 2'b00;    // Register file value
    localparam logic [1:0] FWD_EX   = 2'b01;    // Result of insn in EX
    localparam logic [1:0] FWD_MEM  = 2'b10;    // Result of insn in MEM

    // Exception code zero means the instruction is clean
    localparam logic [EXP_CODE_W-1:0] EXP_NONE = 4'h0;

    ////////////////////////////////////////////////////////////////////////////
    // Machine CSR addresses
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300; // Bit 0 trap active
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341; // Trapped PC
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342; // Trap cause

    // Memory-operation nibble, raw or by field
    typedef union packed {
        logic [3:0] raw;                        // As carried by the pipeline
        struct packed {
            logic       is_load;                // 1xxx
            logic       is_store;               // 01xx when not a load
            logic [1:0] size;                   // Access size
        } fld;                                  // As read by the hazard logic
    } mem_op_u;

endpackage

`default_nettype wire
